//--- logic/cva5_lite_defines.svh
// Core-wide sizing constants for the lite RV32I core
// Data width, register count and reset vector

`ifndef CVA5_LITE_DEFINES_SVH
`define CVA5_LITE_DEFINES_SVH

// Data and address width
`define CVA5_XLEN 32

// Architectural integer registers
`define CVA5_NUM_REGS 32

// Register index width
`define CVA5_REG_ADDR_W 5

// Address of the first instruction fetched after reset
`define CVA5_RESET_PC 32'h0000_0000

`endif

//--- logic/cva5_lite_pkg.sv
// Shared types for the lite RV32I core
// Word and register index types, operation and fetch state encodings

`default_nettype none

`include "cva5_lite_defines.svh"

package cva5_lite_pkg;

    typedef logic [`CVA5_XLEN-1:0]       word_t;
    typedef logic [`CVA5_REG_ADDR_W-1:0] reg_addr_t;

    // Operations chosen by decode
    typedef enum logic [4:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_SLT,
        OP_SLTU,
        OP_LUI,
        OP_JAL,
        OP_BEQ,
        OP_BNE,
        OP_BLT,
        OP_BGE,
        OP_NOP
    } op_e;

    // Instruction bus state
    typedef enum logic {
        FETCH_REQ,
        FETCH_WAIT
    } fetch_state_e;

endpackage

`default_nettype wire

//--- logic/core_if.sv
// Internal pipeline interfaces
// Fetch to decode with its redirect path, and the issue packet to the execute units

`timescale 1ns/1ps
`default_nettype none

//////////////////////////////////////////////////
// Fetched word and redirect back to fetch
interface fetch_if
    import cva5_lite_pkg::*;
();
    logic  valid;
    word_t pc;
    word_t instr;
    logic  redirect;
    word_t redirect_pc;

    modport fetch_src (output valid, pc, instr, input redirect, redirect_pc);
    modport fetch_dst (input valid, pc, instr, redirect, redirect_pc);
    modport redir_src (output redirect, redirect_pc);
endinterface

//////////////////////////////////////////////////
// Registered issue packet
interface issue_if
    import cva5_lite_pkg::*;
();
    logic      valid;
    op_e       op;
    word_t     pc;
    word_t     rs1_val;
    word_t     rs2_val;
    word_t     imm;
    reg_addr_t rd;
    // Second ALU operand comes from imm
    logic      use_imm;

    modport issue_src (output valid, op, pc, rs1_val, rs2_val, imm, rd, use_imm);
    modport issue_dst (input valid, op, pc, rs1_val, rs2_val, imm, rd, use_imm);
endinterface

`default_nettype wire

//--- logic/fetch_unit.sv
// Instruction fetch unit
// Program counter and a Wishbone classic read master, one transfer per word

`timescale 1ns/1ps
`default_nettype none

`include "cva5_lite_defines.svh"

module fetch_unit
    import cva5_lite_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    fetch_if.fetch_src  fetch,
    input  word_t       i_dat_i,
    input  logic        i_ack,
    output logic        i_cyc,
    output logic        i_stb,
    output logic        i_we,
    output word_t       i_adr
);

    fetch_state_e state;
    word_t        next_pc;
    logic         discard;
    logic         accept;

    function automatic word_t word_align(input word_t addr);
        return {addr[`CVA5_XLEN-1:2], 2'b00};
    endfunction

    // Word belongs to the current stream only without a pending or new redirect
    assign accept = (state == FETCH_WAIT) && i_ack && !discard && !fetch.redirect;

    assign i_cyc = (state == FETCH_WAIT);
    assign i_stb = (state == FETCH_WAIT);
    assign i_we  = 1'b0;

    //////////////////////////////////////////////////
    // Bus FSM and program counter
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= FETCH_REQ;
            next_pc     <= `CVA5_RESET_PC;
            i_adr       <= `CVA5_RESET_PC;
            discard     <= 1'b0;
            fetch.valid <= 1'b0;
        end else begin
            fetch.valid <= accept;
            case (state)
                FETCH_REQ: begin
                    state <= FETCH_WAIT;
                    i_adr <= word_align(fetch.redirect ? fetch.redirect_pc : next_pc);
                end
                FETCH_WAIT: begin
                    if (i_ack) begin
                        state   <= FETCH_REQ;
                        discard <= 1'b0;
                    end else if (fetch.redirect) begin
                        // Let the cycle finish, drop its word
                        discard <= 1'b1;
                    end
                end
            endcase
            if (fetch.redirect) begin
                next_pc <= fetch.redirect_pc;
            end else if (accept) begin
                next_pc <= i_adr + word_t'(4);
            end
        end
    end

    // Fetched word and its address
    always_ff @(posedge clk) begin
        if (accept) begin
            fetch.pc    <= i_adr;
            fetch.instr <= i_dat_i;
        end
    end

endmodule

`default_nettype wire

//--- logic/decode_issue.sv
// Decode and issue stage
// Maps the fetched word to an operation, builds the immediate and registers the packet

`timescale 1ns/1ps
`default_nettype none

module decode_issue
    import cva5_lite_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    fetch_if.fetch_dst  fetch,
    output reg_addr_t   rs1_addr,
    output reg_addr_t   rs2_addr,
    input  word_t       rs1_val,
    input  word_t       rs2_val,
    issue_if.issue_src  issue
);

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       r_legal;
    logic       i_legal;
    op_e        dec_op;
    word_t      dec_imm;
    reg_addr_t  dec_rd;
    logic       dec_use_imm;

    function automatic op_e alu_op(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? OP_SUB : OP_ADD;
            3'b001:  return OP_SLL;
            3'b010:  return OP_SLT;
            3'b011:  return OP_SLTU;
            3'b100:  return OP_XOR;
            3'b101:  return alt ? OP_SRA : OP_SRL;
            3'b110:  return OP_OR;
            default: return OP_AND;
        endcase
    endfunction

    assign opcode   = fetch.instr[6:0];
    assign funct3   = fetch.instr[14:12];
    assign funct7   = fetch.instr[31:25];
    assign rs1_addr = fetch.instr[19:15];
    assign rs2_addr = fetch.instr[24:20];

    // Only SUB and SRA take the alternate funct7
    assign r_legal = (funct7 == 7'b0000000)
                  || (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
    // Shift immediates keep funct7 in the upper bits
    assign i_legal = (funct3 == 3'b001) ? (funct7 == 7'b0000000)
                   : (funct3 == 3'b101) ? (funct7 == 7'b0000000 || funct7 == 7'b0100000)
                   : 1'b1;

    //////////////////////////////////////////////////
    // Decode
    always_comb begin
        dec_op      = OP_NOP;
        dec_rd      = '0;
        dec_imm     = {{20{fetch.instr[31]}}, fetch.instr[31:20]};
        dec_use_imm = 1'b0;
        case (opcode)
            OPC_OP: if (r_legal) begin
                dec_op = alu_op(funct3, funct7[5]);
                dec_rd = fetch.instr[11:7];
            end
            OPC_OP_IMM: if (i_legal) begin
                dec_op      = alu_op(funct3, funct3 == 3'b101 && funct7[5]);
                dec_rd      = fetch.instr[11:7];
                dec_use_imm = 1'b1;
            end
            OPC_LUI: begin
                dec_op  = OP_LUI;
                dec_rd  = fetch.instr[11:7];
                dec_imm = {fetch.instr[31:12], 12'b0};
            end
            OPC_JAL: begin
                dec_op  = OP_JAL;
                dec_rd  = fetch.instr[11:7];
                dec_imm = {{11{fetch.instr[31]}}, fetch.instr[31], fetch.instr[19:12],
                           fetch.instr[20], fetch.instr[30:21], 1'b0};
            end
            OPC_BRANCH: begin
                dec_imm = {{19{fetch.instr[31]}}, fetch.instr[31], fetch.instr[7],
                           fetch.instr[30:25], fetch.instr[11:8], 1'b0};
                case (funct3)
                    3'b000:  dec_op = OP_BEQ;
                    3'b001:  dec_op = OP_BNE;
                    3'b100:  dec_op = OP_BLT;
                    3'b101:  dec_op = OP_BGE;
                    default: dec_op = OP_NOP;
                endcase
            end
            default: ;
        endcase
    end

    //////////////////////////////////////////////////
    // Issue register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            issue.valid <= 1'b0;
        end else begin
            // Word fetched behind a taken branch is dropped
            issue.valid <= fetch.valid && !fetch.redirect;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch.valid) begin
            issue.op      <= dec_op;
            issue.pc      <= fetch.pc;
            issue.rs1_val <= rs1_val;
            issue.rs2_val <= rs2_val;
            issue.imm     <= dec_imm;
            issue.rd      <= dec_rd;
            issue.use_imm <= dec_use_imm;
        end
    end

endmodule

`default_nettype wire

//--- logic/register_file.sv
// Integer register file
// Two read ports, one write port, x0 hard-wired to zero, write data bypassed to reads

`timescale 1ns/1ps
`default_nettype none

`include "cva5_lite_defines.svh"

module register_file
    import cva5_lite_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  reg_addr_t rs1_addr,
    input  reg_addr_t rs2_addr,
    output word_t     rs1_val,
    output word_t     rs2_val,
    input  logic      wr_en,
    input  reg_addr_t wr_addr,
    input  word_t     wr_data
);

    word_t regs [`CVA5_NUM_REGS];

    // Same-cycle write wins over the stored value
    function automatic word_t read_port(input reg_addr_t addr);
        if (wr_en && addr == wr_addr && addr != '0) begin
            return wr_data;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `CVA5_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    always_comb begin
        rs1_val = read_port(rs1_addr);
        rs2_val = read_port(rs2_addr);
    end

endmodule

`default_nettype wire

//--- logic/alu_unit.sv
// Single-cycle integer ALU
// Computes the result, writes the register file and reports each instruction on commit

`timescale 1ns/1ps
`default_nettype none

`include "cva5_lite_defines.svh"

module alu_unit
    import cva5_lite_pkg::*;
(
    issue_if.issue_dst issue,
    output logic       wr_en,
    output reg_addr_t  wr_addr,
    output word_t      wr_data,
    output logic       commit_valid,
    output word_t      commit_pc,
    output reg_addr_t  commit_rd,
    output word_t      commit_value
);

    localparam int SHAMT_W = $clog2(`CVA5_XLEN);

    word_t               op_b;
    logic [SHAMT_W-1:0]  shamt;
    word_t               result;

    assign op_b  = issue.use_imm ? issue.imm : issue.rs2_val;
    assign shamt = op_b[SHAMT_W-1:0];

    always_comb begin
        case (issue.op)
            OP_ADD:  result = issue.rs1_val + op_b;
            OP_SUB:  result = issue.rs1_val - op_b;
            OP_AND:  result = issue.rs1_val & op_b;
            OP_OR:   result = issue.rs1_val | op_b;
            OP_XOR:  result = issue.rs1_val ^ op_b;
            OP_SLL:  result = issue.rs1_val << shamt;
            OP_SRL:  result = issue.rs1_val >> shamt;
            OP_SRA:  result = word_t'($signed(issue.rs1_val) >>> shamt);
            OP_SLT:  result = word_t'($signed(issue.rs1_val) < $signed(op_b));
            OP_SLTU: result = word_t'(issue.rs1_val < op_b);
            OP_LUI:  result = issue.imm;
            // Link address
            OP_JAL:  result = issue.pc + word_t'(4);
            default: result = '0;
        endcase
    end

    // Every issued instruction commits, branches and no-ops with rd zero
    assign commit_valid = issue.valid;
    assign commit_pc    = issue.pc;
    assign commit_rd    = issue.rd;
    assign commit_value = result;

    assign wr_en   = issue.valid && (issue.rd != '0);
    assign wr_addr = issue.rd;
    assign wr_data = result;

endmodule

`default_nettype wire

//--- logic/branch_unit.sv
// Branch unit
// Resolves conditional branches and JAL and redirects fetch on a taken one

`timescale 1ns/1ps
`default_nettype none

module branch_unit
    import cva5_lite_pkg::*;
(
    issue_if.issue_dst issue,
    fetch_if.redir_src fetch
);

    logic equal;
    logic less;
    logic taken;

    assign equal = (issue.rs1_val == issue.rs2_val);
    assign less  = ($signed(issue.rs1_val) < $signed(issue.rs2_val));

    //////////////////////////////////////////////////
    // Branch condition
    always_comb begin
        case (issue.op)
            OP_BEQ:  taken = equal;
            OP_BNE:  taken = !equal;
            OP_BLT:  taken = less;
            OP_BGE:  taken = !less;
            OP_JAL:  taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    // Held for the single issue cycle
    assign fetch.redirect    = issue.valid && taken;
    assign fetch.redirect_pc = issue.pc + issue.imm;

endmodule

`default_nettype wire

//--- logic/cva5_lite_top.sv
// Lite RV32I core top level
// Wishbone classic instruction bus in, commit port out

`timescale 1ns/1ps
`default_nettype none

module cva5_lite_top
    import cva5_lite_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  word_t     i_dat_i,
    input  logic      i_ack,
    output logic      i_cyc,
    output logic      i_stb,
    output logic      i_we,
    output word_t     i_adr,
    output logic      commit_valid,
    output word_t     commit_pc,
    output reg_addr_t commit_rd,
    output word_t     commit_value
);

    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t     rs1_val;
    word_t     rs2_val;
    logic      wr_en;
    reg_addr_t wr_addr;
    word_t     wr_data;

    fetch_if fetch_bus ();
    issue_if issue_bus ();

    //////////////////////////////////////////////////
    // Front end
    fetch_unit fetch_unit_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .fetch   (fetch_bus),
        .i_dat_i (i_dat_i),
        .i_ack   (i_ack),
        .i_cyc   (i_cyc),
        .i_stb   (i_stb),
        .i_we    (i_we),
        .i_adr   (i_adr)
    );

    decode_issue decode_issue_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .fetch    (fetch_bus),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_val  (rs1_val),
        .rs2_val  (rs2_val),
        .issue    (issue_bus)
    );

    register_file register_file_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_val  (rs1_val),
        .rs2_val  (rs2_val),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data)
    );

    //////////////////////////////////////////////////
    // Execute
    alu_unit alu_unit_inst (
        .issue        (issue_bus),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .commit_valid (commit_valid),
        .commit_pc    (commit_pc),
        .commit_rd    (commit_rd),
        .commit_value (commit_value)
    );

    branch_unit branch_unit_inst (
        .issue (issue_bus),
        .fetch (fetch_bus)
    );

endmodule

`default_nettype wire

//--- verif/cva5_lite_checker.sv
// Protocol checker for the lite core
// Wishbone instruction bus rules and commit behavior under reset

`timescale 1ns/1ps
`default_nettype none

module cva5_lite_checker (
    input wire logic        clk,
    input wire logic        rst_n,
    input wire logic        i_cyc,
    input wire logic        i_stb,
    input wire logic        i_we,
    input wire logic        i_ack,
    input wire logic [31:0] i_adr,
    input wire logic        commit_valid
);

    // Strobe only inside a bus cycle
    a_stb_in_cyc: assert property (@(posedge clk) disable iff (!rst_n) i_stb |-> i_cyc)
        else $error("i_stb high without i_cyc");

    // Address held until the slave acknowledges
    a_adr_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (i_stb && !i_ack) |=> $stable(i_adr))
        else $error("i_adr changed during a pending transfer");

    a_read_only: assert property (@(posedge clk) !i_we)
        else $error("i_we raised on the instruction bus");

    a_no_commit_in_reset: assert property (@(posedge clk) (!rst_n ##1 !rst_n) |-> !commit_valid)
        else $error("commit_valid high during reset");

endmodule

bind cva5_lite_top cva5_lite_checker cva5_lite_checker_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_cyc        (i_cyc),
    .i_stb        (i_stb),
    .i_we         (i_we),
    .i_ack        (i_ack),
    .i_adr        (i_adr),
    .commit_valid (commit_valid)
);

`default_nettype wire

//--- verif/cva5_lite_tb.sv
// Testbench for the lite RV32I core
// Wishbone memory model, ISA reference model and directed tests on the commit port

`timescale 1ns/1ps
`default_nettype none

`include "cva5_lite_defines.svh"

module cva5_lite_tb;

    logic        clk;
    logic        rst_n;
    logic [31:0] i_dat_i;
    logic        i_ack;
    logic        i_cyc;
    logic        i_stb;
    logic        i_we;
    logic [31:0] i_adr;
    logic        commit_valid;
    logic [31:0] commit_pc;
    logic [4:0]  commit_rd;
    logic [31:0] commit_value;

    logic [31:0] mem [0:255];
    int          prog_len;
    int          errors;
    int          cycle;
    int          seed = 32'hb646_de01;
    bit          use_waits;
    int          wait_left;
    logic [31:0] exp_pc[$];
    logic [4:0]  exp_rd[$];
    logic [31:0] exp_val[$];
    logic [31:0] got_pc[$];
    logic [4:0]  got_rd[$];
    logic [31:0] got_val[$];
    int          got_cyc[$];
    int          ack_cyc[$];

    cva5_lite_top cva5_lite_top_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_dat_i      (i_dat_i),
        .i_ack        (i_ack),
        .i_cyc        (i_cyc),
        .i_stb        (i_stb),
        .i_we         (i_we),
        .i_adr        (i_adr),
        .commit_valid (commit_valid),
        .commit_pc    (commit_pc),
        .commit_rd    (commit_rd),
        .commit_value (commit_value)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // Wishbone slave with optional random wait states
    always @(posedge clk) begin
        #1;
        if (!(i_cyc && i_stb) || i_ack) begin
            i_ack     = 1'b0;
            wait_left = -1;
        end else begin
            if (wait_left < 0) begin
                wait_left = use_waits ? ($random(seed) & 3) : 0;
            end
            if (wait_left == 0) begin
                i_ack   = 1'b1;
                i_dat_i = mem[i_adr[9:2]];
            end else begin
                wait_left = wait_left - 1;
            end
        end
    end

    // Commit and ack capture
    always @(posedge clk) begin
        if (rst_n && i_cyc && i_stb && i_ack) begin
            ack_cyc.push_back(cycle);
        end
        if (rst_n && commit_valid) begin
            got_pc.push_back(commit_pc);
            got_rd.push_back(commit_rd);
            got_val.push_back(commit_value);
            got_cyc.push_back(cycle);
        end
        cycle = cycle + 1;
    end

    // Instruction encoders
    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    // RV32I integer result for funct3 with the alternate bit
    function automatic logic [31:0] model_alu(input logic [2:0] f3, input logic alt,
                                              input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'b0, $signed(a) < $signed(b)};
            3'd3:    return {31'b0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic emit(input logic [31:0] word);
        mem[prog_len] = word;
        prog_len++;
    endtask

    task automatic clear_memory();
        // ADDI x0, x0, imm with the word index as imm
        for (int i = 0; i < 256; i++) begin
            mem[i] = {4'b0, i[7:0], 20'h00013};
        end
        prog_len = 0;
    endtask

    //////////////////////////////////////////////////
    // ISA model producing the expected commit stream
    task automatic run_model(input int n);
        logic [31:0] r [32];
        logic [31:0] pc;
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] val;
        logic [31:0] nxt;
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic        take;
        for (int i = 0; i < 32; i++) begin
            r[i] = '0;
        end
        pc = `CVA5_RESET_PC;
        for (int k = 0; k < n; k++) begin
            ins   = mem[pc[9:2]];
            f3    = ins[14:12];
            f7    = ins[31:25];
            a     = r[ins[19:15]];
            b     = r[ins[24:20]];
            imm_i = {{20{ins[31]}}, ins[31:20]};
            rd    = '0;
            val   = '0;
            nxt   = pc + 4;
            case (ins[6:0])
                7'b0110011: if (f7 == 0 || (f7 == 7'h20 && (f3 == 0 || f3 == 5))) begin
                    rd  = ins[11:7];
                    val = model_alu(f3, f7[5], a, b);
                end
                7'b0010011: if (!(f3 == 1 && f7 != 0) && !(f3 == 5 && f7 != 0 && f7 != 7'h20)) begin
                    rd  = ins[11:7];
                    val = model_alu(f3, f3 == 5 && f7[5], a, imm_i);
                end
                7'b0110111: begin
                    rd  = ins[11:7];
                    val = {ins[31:12], 12'b0};
                end
                7'b1101111: begin
                    rd  = ins[11:7];
                    val = pc + 4;
                    nxt = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
                end
                7'b1100011: begin
                    case (f3)
                        3'd0:    take = (a == b);
                        3'd1:    take = (a != b);
                        3'd4:    take = ($signed(a) < $signed(b));
                        3'd5:    take = ($signed(a) >= $signed(b));
                        default: take = 1'b0;
                    endcase
                    if (take) begin
                        nxt = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
                    end
                end
                default: ;
            endcase
            exp_pc.push_back(pc);
            exp_rd.push_back(rd);
            exp_val.push_back(val);
            if (rd != 0) begin
                r[rd] = val;
            end
            pc = nxt;
        end
    endtask

    task automatic check_val(input string name, input string what,
                             input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act) else begin
            $display("** Error [%s] %s: expected %h, actual %h", name, what, exp, act);
            errors++;
        end
    endtask

    //////////////////////////////////////////////////
    // Reset with quiet bus and commit checks, followed by the first request
    task automatic reset_dut(input string name);
        int t;
        rst_n = 1'b0;
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            #1;
            if (i > 0) begin
                check_val(name, "i_cyc in reset", 0, i_cyc);
                check_val(name, "commit_valid in reset", 0, commit_valid);
            end
        end
        exp_pc.delete();
        exp_rd.delete();
        exp_val.delete();
        got_pc.delete();
        got_rd.delete();
        got_val.delete();
        got_cyc.delete();
        ack_cyc.delete();
        rst_n = 1'b1;
        t = 0;
        while (!i_cyc && t < 20) begin
            @(posedge clk);
            #1;
            t++;
        end
        assert (i_cyc) else begin
            $display("%s: no bus request after reset", name);
            errors++;
        end
        check_val(name, "first i_adr", `CVA5_RESET_PC, i_adr);
    endtask

    // Run n instructions against the model with optional ack to commit timing
    task automatic run_and_compare(input string name, input int n, input bit timing);
        int t;
        reset_dut(name);
        run_model(n);
        t = 0;
        while (got_pc.size() < n && t < 60 * n + 100) begin
            @(posedge clk);
            #1;
            t++;
        end
        assert (got_pc.size() >= n) else begin
            $display("%s: timed out with %0d of %0d commits", name, got_pc.size(), n);
            errors++;
        end
        for (int k = 0; k < n && k < got_pc.size(); k++) begin
            check_val(name, $sformatf("commit %0d pc", k), exp_pc[k], got_pc[k]);
            check_val(name, $sformatf("commit %0d rd", k), exp_rd[k], got_rd[k]);
            if (exp_rd[k] != 0) begin
                check_val(name, $sformatf("commit %0d value", k), exp_val[k], got_val[k]);
            end
            if (timing) begin
                check_val(name, $sformatf("commit %0d cycle", k), ack_cyc[k] + 2, got_cyc[k]);
            end
        end
    endtask

    task automatic load_alu_program();
        clear_memory();
        emit({20'h12345, 5'd1, 7'b0110111});
        emit(i_type(-12'sd7, 0, 3'd0, 2));
        emit(i_type(12'd5, 0, 3'd0, 3));
        emit(r_type(0, 2, 1, 3'd0, 4));
        emit(r_type(7'h20, 3, 2, 3'd0, 5));
        emit(r_type(0, 2, 1, 3'd7, 6));
        emit(r_type(0, 3, 1, 3'd6, 7));
        emit(r_type(0, 2, 1, 3'd4, 8));
        emit(r_type(0, 3, 1, 3'd1, 9));
        emit(r_type(0, 3, 2, 3'd5, 10));
        emit(r_type(7'h20, 3, 2, 3'd5, 11));
        emit(r_type(0, 3, 2, 3'd2, 12));
        emit(r_type(0, 3, 2, 3'd3, 13));
        emit(i_type(12'h0f0, 1, 3'd7, 14));
        emit(i_type(12'h80f, 1, 3'd6, 15));
        emit(i_type(12'hfff, 1, 3'd4, 16));
        emit(i_type({7'h00, 5'd4}, 1, 3'd1, 17));
        emit(i_type({7'h00, 5'd8}, 2, 3'd5, 18));
        emit(i_type({7'h20, 5'd8}, 2, 3'd5, 19));
        emit(i_type(-12'sd3, 2, 3'd2, 20));
        emit(i_type(12'd9, 3, 3'd3, 21));
        emit(j_type(0, 0));
    endtask

    task automatic test_alu();
        load_alu_program();
        run_and_compare("alu", prog_len, 1'b0);
    endtask

    task automatic test_deps();
        clear_memory();
        emit(i_type(12'd1, 0, 3'd0, 1));
        emit(r_type(0, 1, 1, 3'd0, 1));
        emit(r_type(0, 1, 1, 3'd0, 1));
        emit(r_type(0, 1, 1, 3'd0, 1));
        emit(r_type(0, 0, 1, 3'd0, 2));
        emit(r_type(7'h20, 2, 0, 3'd0, 3));
        emit(i_type(12'd5, 0, 3'd0, 0));
        emit(r_type(0, 3, 0, 3'd0, 4));
        emit(r_type(0, 4, 4, 3'd6, 5));
        emit(j_type(0, 0));
        run_and_compare("deps", prog_len, 1'b0);
    endtask

    task automatic test_branch();
        clear_memory();
        emit(i_type(12'd3, 0, 3'd0, 1));
        emit(i_type(-12'sd1, 0, 3'd0, 2));
        emit(b_type(13'd8, 1, 1, 3'd0));
        emit(i_type(12'd99, 0, 3'd0, 5));
        emit(b_type(13'd8, 1, 1, 3'd1));
        emit(b_type(13'd8, 1, 2, 3'd4));
        emit(i_type(12'd98, 0, 3'd0, 6));
        emit(b_type(13'd8, 1, 2, 3'd5));
        emit(b_type(13'd8, 2, 1, 3'd5));
        emit(i_type(12'd97, 0, 3'd0, 9));
        emit(b_type(13'd8, 2, 1, 3'd4));
        emit(b_type(13'd8, 2, 1, 3'd0));
        emit(b_type(13'd8, 2, 1, 3'd1));
        emit(i_type(12'd96, 0, 3'd0, 10));
        emit(j_type(21'd8, 7));
        emit(i_type(12'd95, 0, 3'd0, 11));
        emit(i_type(12'd1, 7, 3'd0, 8));
        emit(j_type(0, 0));
        run_and_compare("branch", 14, 1'b0);
    endtask

    task automatic test_wait_states();
        load_alu_program();
        use_waits = 1'b1;
        run_and_compare("waits", prog_len, 1'b1);
        use_waits = 1'b0;
    endtask

    initial begin
        rst_n     = 1'b0;
        i_ack     = 1'b0;
        i_dat_i   = '0;
        errors    = 0;
        cycle     = 0;
        use_waits = 1'b0;
        wait_left = -1;
        clear_memory();
        reset_dut("reset");
        test_alu();
        test_deps();
        test_branch();
        test_wait_states();
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
+incdir+logic
logic/cva5_lite_pkg.sv
logic/core_if.sv
logic/fetch_unit.sv
logic/decode_issue.sv
logic/register_file.sv
logic/alu_unit.sv
logic/branch_unit.sv
logic/cva5_lite_top.sv
verif/cva5_lite_checker.sv
verif/cva5_lite_tb.sv

//--- Makefile
# Verilator build and run for the lite RV32I core

VERILATOR ?= verilator
TOP       ?= cva5_lite_tb
BUILD_DIR ?= obj_dir
FILELIST  ?= files.f
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "TEST OK"

clean:
	rm -rf $(BUILD_DIR)
